//--- Bender.yml
package:
  name: rename_dispatch

sources:
  - src/rename_pkg.sv
  - src/inst_queue.sv
  - src/free_list.sv
  - src/rename_table.sv
  - src/phys_reg_status.sv
  - src/dispatcher.sv
  - src/rename_dispatch_top.sv
  - target: test
    files:
      - bench/rename_dispatch_props.sv
      - bench/rename_dispatch_checker.sv
      - bench/rename_dispatch_tb.sv

//--- bench/rename_dispatch_checker.sv
// Dispatch checker, reference model of alias table, free list and busy bits
module rename_dispatch_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inst_push,
    input  rename_pkg::inst_info_t      inst_in,
    input  rename_pkg::phys_reg_t       exp_rd,
    input  logic                        check_latency,
    input  logic                        exp_full,
    input  logic                        wb_valid,
    input  rename_pkg::phys_reg_t       wb_preg,
    input  logic                        free_valid,
    input  rename_pkg::phys_reg_t       free_preg,
    input  logic                        inst_q_full,
    input  logic                        dispatch_valid,
    input  rename_pkg::dispatch_entry_t dispatch_entry,
    output int                          errors,
    output int                          dispatched
);

    // Pushed and not yet dispatched, with table rd, latency flag and push cycle
    rename_pkg::inst_info_t           pend_inst [$];
    rename_pkg::phys_reg_t            pend_rd [$];
    logic                             pend_lat [$];
    int                               pend_cycle [$];
    // Model state
    rename_pkg::phys_reg_t            free_q [$];
    rename_pkg::phys_reg_t            map [rename_pkg::arch_regs];
    logic [rename_pkg::phys_regs-1:0] busy;
    int                               cycle;

    // Ready unless busy, a writeback in the same cycle counts as ready
    function automatic logic is_ready(rename_pkg::phys_reg_t p);
        return !busy[p] || (wb_valid && (wb_preg == p));
    endfunction

    always @(posedge clk) begin
        rename_pkg::dispatch_entry_t want;
        rename_pkg::phys_reg_t       table_rd;
        logic                        lat_on;
        int                          pushed_at;
        logic                        set_on;
        if (rst) begin
            pend_inst.delete();
            pend_rd.delete();
            pend_lat.delete();
            pend_cycle.delete();
            free_q.delete();
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                free_q.push_back(rename_pkg::phys_reg_t'(rename_pkg::arch_regs + i));
                map[i] = rename_pkg::phys_reg_t'(i);
            end
            busy       = '0;
            cycle      = 0;
            errors     = 0;
            dispatched = 0;
        end else begin
            cycle++;
            set_on = 1'b0;
            // Queue full level during this row
            if (inst_q_full !== exp_full) begin
                $display("[ERROR] %0t: inst_q_full %b, expected %b", $time,
                         inst_q_full, exp_full);
                errors++;
            end
            if (dispatch_valid && (pend_inst.size() == 0)) begin
                $display("[ERROR] %0t: dispatch with no instruction pending", $time);
                errors++;
            end else if (dispatch_valid) begin
                want       = '0;
                want.inst  = pend_inst.pop_front();
                table_rd   = pend_rd.pop_front();
                lat_on     = pend_lat.pop_front();
                pushed_at  = pend_cycle.pop_front();
                want.rob_id = rename_pkg::rob_id_t'(dispatched);
                want.input1_met = 1'b1;
                want.input2_met = 1'b1;
                // Unused sources stay on register 0 and are met
                if (want.inst.uses_rs1) begin
                    want.rat.rs1    = map[want.inst.rs1_s];
                    want.input1_met = is_ready(want.rat.rs1);
                end
                if (!want.inst.uses_imm) begin
                    want.rat.rs2    = map[want.inst.rs2_s];
                    want.input2_met = is_ready(want.rat.rs2);
                end
                // Registers come out in list order
                if (want.inst.has_rd && (free_q.size() > 0)) begin
                    want.rat.rd = free_q.pop_front();
                    set_on      = 1'b1;
                end
                if (dispatch_entry !== want) begin
                    $display("[ERROR] %0t: entry %h, expected %h", $time, dispatch_entry, want);
                    errors++;
                end
                if (want.rat.rd != table_rd) begin
                    $display("[ERROR] %0t: model rd %0d, table rd %0d", $time,
                             want.rat.rd, table_rd);
                    errors++;
                end
                if (lat_on && ((cycle - pushed_at) != 2)) begin
                    $display("[ERROR] %0t: dispatched %0d cycles after push, expected 2",
                             $time, cycle - pushed_at);
                    errors++;
                end
                if (set_on && (want.inst.rd_s != '0)) begin
                    map[want.inst.rd_s] = want.rat.rd;
                end
                dispatched++;
            end
            if (wb_valid) begin
                busy[wb_preg] = 1'b0;
            end
            // New rename wins over a writeback of the same register
            if (set_on) begin
                busy[want.rat.rd] = 1'b1;
            end
            if (free_valid) begin
                free_q.push_back(free_preg);
            end
            if (inst_push) begin
                pend_inst.push_back(inst_in);
                pend_rd.push_back(exp_rd);
                pend_lat.push_back(check_latency);
                pend_cycle.push_back(cycle);
            end
        end
    end

endmodule

//--- bench/rename_dispatch_props.sv
// Dispatcher properties on reset, back-pressure and alias table writes
module rename_dispatch_props (
    input logic clk,
    input logic rst,
    input logic pop_inst,
    input logic rs_full,
    input logic rob_full,
    input logic rat_we,
    input logic dispatch_valid
);

    // Failed assertions, read by the testbench
    int fails = 0;

    // Valid is cleared by reset
    assert property (@(posedge clk) rst |=> !dispatch_valid)
        else begin
            $error("dispatch_valid high after a reset cycle");
            fails++;
        end

    // Back-pressure blocks the pop in the same cycle
    assert property (@(posedge clk) disable iff (rst) (rs_full || rob_full) |-> !pop_inst)
        else begin
            $error("pop_inst high while rs_full or rob_full");
            fails++;
        end

    // Alias table only written during a dispatch
    assert property (@(posedge clk) disable iff (rst) rat_we |-> dispatch_valid)
        else begin
            $error("rat_we high without dispatch_valid");
            fails++;
        end

endmodule

//--- bench/rename_dispatch_tb.sv
// Testbench for the rename and dispatch front end, table driven with a reference checker
module rename_dispatch_tb;

    // One stimulus row per clock cycle
    typedef struct packed {
        logic                   push;
        rename_pkg::inst_info_t inst;
        rename_pkg::phys_reg_t  exp_rd;
        logic                   check_latency;
        // Queue full level expected during the row
        logic                   exp_full;
        logic                   rs_full;
        logic                   rob_full;
        logic                   wb_valid;
        rename_pkg::phys_reg_t  wb_preg;
        logic                   free_valid;
        rename_pkg::phys_reg_t  free_preg;
        logic [2:0]             group;
    } row_t;

    logic                        clk;
    logic                        rst;
    logic                        inst_q_full;
    logic                        dispatch_valid;
    rename_pkg::dispatch_entry_t dispatch_entry;
    rename_pkg::rob_id_t         rob_id_next = '0;
    int                          errors;
    int                          dispatched;

    row_t        rows [$];
    // Row on the DUT inputs, and the defaults new rows start from
    row_t        cur;
    row_t        proto;
    logic [31:0] lcg_state = 32'hab39_5c0b;
    int          pushes = 0;
    int          group_base = 0;
    string       test_names [5] = '{"in-order allocation", "source renaming",
                                    "operand readiness", "back-pressure",
                                    "free list exhaustion"};

    rename_dispatch_top i_dut (
        .clk, .rst,
        .inst_push(cur.push), .inst_in(cur.inst), .inst_q_full,
        .rs_full(cur.rs_full), .rob_full(cur.rob_full), .rob_id_next,
        .wb_valid(cur.wb_valid), .wb_preg(cur.wb_preg),
        .free_valid(cur.free_valid), .free_preg(cur.free_preg),
        .dispatch_valid, .dispatch_entry
    );

    rename_dispatch_checker i_checker (
        .clk, .rst,
        .inst_push(cur.push), .inst_in(cur.inst), .exp_rd(cur.exp_rd),
        .check_latency(cur.check_latency), .exp_full(cur.exp_full),
        .wb_valid(cur.wb_valid), .wb_preg(cur.wb_preg),
        .free_valid(cur.free_valid), .free_preg(cur.free_preg),
        .inst_q_full,
        .dispatch_valid, .dispatch_entry, .errors, .dispatched
    );

    bind dispatcher rename_dispatch_props u_props (
        .clk(clk), .rst(rst), .pop_inst(pop_inst), .rs_full(rs_full),
        .rob_full(rob_full), .rat_we(rat_we), .dispatch_valid(dispatch_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Tag of the next reorder buffer entry follows the dispatch count
    always @(negedge clk) begin
        rob_id_next <= rename_pkg::rob_id_t'(dispatched);
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int total_errors();
        return errors + i_dut.i_dispatcher.u_props.fails;
    endfunction

    task automatic idle_rows(int n);
        for (int i = 0; i < n; i++) begin
            rows.push_back(proto);
        end
    endtask

    task automatic wb_row(rename_pkg::phys_reg_t p);
        row_t r;
        r          = proto;
        r.wb_valid = 1'b1;
        r.wb_preg  = p;
        rows.push_back(r);
    endtask

    task automatic free_row(rename_pkg::phys_reg_t p);
        row_t r;
        r            = proto;
        r.free_valid = 1'b1;
        r.free_preg  = p;
        rows.push_back(r);
    endtask

    // x0 as rd means no destination
    task automatic push_op(rename_pkg::arch_reg_t rd, rename_pkg::arch_reg_t rs1,
                           rename_pkg::arch_reg_t rs2, logic uses_rs1, logic uses_imm,
                           rename_pkg::phys_reg_t exp);
        row_t r;
        r               = proto;
        r.push          = 1'b1;
        r.exp_rd        = exp;
        r.inst.pc       = 32'(rows.size() * 4);
        r.inst.inst     = next_rand();
        r.inst.rs1_s    = rs1;
        r.inst.rs2_s    = rs2;
        r.inst.rd_s     = rd;
        r.inst.uses_rs1 = uses_rs1;
        r.inst.uses_imm = uses_imm;
        r.inst.has_rd   = (rd != '0);
        rows.push_back(r);
    endtask

    task automatic build_table();
        // Allocation from 32 upward, spaced then back to back
        proto.group         = 3'd0;
        proto.check_latency = 1'b1;
        push_op(5'd1, 5'd2, 5'd3, 1'b1, 1'b0, 6'd32);
        idle_rows(3);
        push_op(5'd2, 5'd1, 5'd0, 1'b1, 1'b0, 6'd33);
        idle_rows(3);
        push_op(5'd3, 5'd1, 5'd2, 1'b1, 1'b0, 6'd34);
        push_op(5'd4, 5'd3, 5'd3, 1'b1, 1'b0, 6'd35);
        push_op(5'd1, 5'd4, 5'd0, 1'b1, 1'b1, 6'd36);
        idle_rows(4);
        // Newest renames, then a store and an x0 write that take no register
        proto.group = 3'd1;
        push_op(5'd5, 5'd1, 5'd2, 1'b1, 1'b0, 6'd37);
        push_op(5'd0, 5'd5, 5'd1, 1'b1, 1'b0, 6'd0);
        push_op(5'd0, 5'd3, 5'd0, 1'b1, 1'b1, 6'd0);
        push_op(5'd6, 5'd5, 5'd6, 1'b1, 1'b0, 6'd38);
        idle_rows(4);
        // Reader of x7 sees it busy, later written back
        proto.group = 3'd2;
        push_op(5'd7, 5'd0, 5'd0, 1'b1, 1'b0, 6'd39);
        push_op(5'd8, 5'd7, 5'd0, 1'b1, 1'b1, 6'd40);
        idle_rows(2);
        wb_row(6'd39);
        push_op(5'd9, 5'd7, 5'd8, 1'b1, 1'b0, 6'd41);
        push_op(5'd10, 5'd9, 5'd9, 1'b1, 1'b0, 6'd42);
        idle_rows(1);
        // Lands on the dispatch cycle of the x9 reader
        wb_row(6'd41);
        push_op(5'd11, 5'd8, 5'd0, 1'b0, 1'b1, 6'd43);
        idle_rows(4);
        // One entry in flight when rs_full rises, then rob_full while the queue fills
        proto.group         = 3'd3;
        proto.check_latency = 1'b0;
        push_op(5'd12, 5'd10, 5'd11, 1'b1, 1'b0, 6'd44);
        push_op(5'd13, 5'd12, 5'd12, 1'b1, 1'b0, 6'd45);
        proto.rs_full = 1'b1;
        push_op(5'd12, 5'd13, 5'd0, 1'b1, 1'b1, 6'd46);
        push_op(5'd14, 5'd12, 5'd13, 1'b1, 1'b0, 6'd47);
        idle_rows(3);
        proto.rs_full  = 1'b0;
        proto.rob_full = 1'b1;
        // Stores take the last five slots and no register
        for (int k = 0; k < 5; k++) begin
            push_op(5'd0, rename_pkg::arch_reg_t'(10 + k), 5'd12, 1'b1, 1'b0, 6'd0);
        end
        // Full until the first pop after release
        proto.exp_full = 1'b1;
        idle_rows(1);
        proto.rob_full = 1'b0;
        idle_rows(1);
        proto.exp_full = 1'b0;
        idle_rows(8);
        // Drain the free list, stall, then reuse returns in order
        proto.group         = 3'd4;
        proto.check_latency = 1'b1;
        for (int k = 0; k < 16; k++) begin
            push_op(rename_pkg::arch_reg_t'(15 + k), rename_pkg::arch_reg_t'(14 + k), 5'd1,
                    1'b1, 1'b0, rename_pkg::phys_reg_t'(48 + k));
        end
        proto.check_latency = 1'b0;
        push_op(5'd31, 5'd30, 5'd0, 1'b1, 1'b1, 6'd33);
        push_op(5'd2, 5'd31, 5'd0, 1'b1, 1'b1, 6'd32);
        idle_rows(4);
        free_row(6'd33);
        free_row(6'd32);
        idle_rows(6);
    endtask

    task automatic report_group(logic [2:0] g);
        int now;
        now = total_errors();
        $display("Test %0d, %s: %0d mismatches", int'(g) + 1, test_names[g], now - group_base);
        group_base = now;
    endtask

    initial begin
        int   n;
        logic timed_out;
        proto = '0;
        cur   = '0;
        rst   = 1'b1;
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            if ((i > 0) && (rows[i].group != rows[i-1].group)) begin
                report_group(rows[i-1].group);
            end
            cur = rows[i];
            if (cur.push) begin
                pushes++;
            end
            @(negedge clk);
        end
        cur = '0;
        // Last dispatches, bounded
        n = 0;
        while ((dispatched < pushes) && (n < 64)) begin
            @(negedge clk);
            n++;
        end
        timed_out = (dispatched < pushes);
        if (timed_out) begin
            $display("Timeout: only %0d of %0d instructions were dispatched", dispatched, pushes);
        end
        report_group(rows[rows.size()-1].group);
        $display("%0d rows, %0d pushed, %0d dispatched, %0d errors", rows.size(), pushes,
                 dispatched, total_errors());
        if (timed_out || (total_errors() != 0)) begin
            $display("tests failed");
        end else begin
            $display("all tests passed");
        end
        $finish;
    end

endmodule

//--- rename_dispatch.f
src/rename_pkg.sv
src/inst_queue.sv
src/free_list.sv
src/rename_table.sv
src/phys_reg_status.sv
src/dispatcher.sv
src/rename_dispatch_top.sv
bench/rename_dispatch_props.sv
bench/rename_dispatch_checker.sv
bench/rename_dispatch_tb.sv

//--- src/dispatcher.sv
// Dispatcher, stalls, issues rename requests and builds the dispatch entry
module dispatcher (
    input  logic                        clk,
    input  logic                        rst,
    // Instruction queue
    input  logic                        q_empty,
    input  rename_pkg::inst_info_t      q_head,
    input  rename_pkg::inst_info_t      q_inst,
    output logic                        pop_inst,
    // Back-pressure and free list
    input  logic                        rs_full,
    input  logic                        rob_full,
    input  logic                        fl_empty,
    output logic                        fl_pop,
    input  rename_pkg::phys_reg_t       free_preg,
    // Alias table lookups
    output rename_pkg::arch_reg_t       rat_rs1_s,
    output rename_pkg::arch_reg_t       rat_rs2_s,
    input  rename_pkg::phys_reg_t       rat_rs1_p,
    input  rename_pkg::phys_reg_t       rat_rs2_p,
    // Alias table and busy bit update
    output logic                        rat_we,
    output rename_pkg::arch_reg_t       rat_rd_s,
    output rename_pkg::phys_reg_t       rat_rd_p,
    // Busy state of the renamed sources
    input  logic                        busy1,
    input  logic                        busy2,
    input  rename_pkg::rob_id_t         rob_id_next,
    output logic                        dispatch_valid,
    output rename_pkg::dispatch_entry_t dispatch_entry
);

    // Pop needs room downstream and a free register when the head writes rd
    assign pop_inst = !q_empty && !rs_full && !rob_full && (!q_head.has_rd || !fl_empty);

    // Only instructions with a destination consume a register
    assign fl_pop = pop_inst && q_head.has_rd;

    // Popped entry and its register arrive one cycle after the pop
    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_valid <= 1'b0;
        end else begin
            dispatch_valid <= pop_inst;
        end
    end

    // Source lookups follow the popped instruction
    assign rat_rs1_s = q_inst.rs1_s;
    assign rat_rs2_s = q_inst.rs2_s;

    // New mapping lands on the closing edge of the dispatch cycle
    assign rat_we   = dispatch_valid && q_inst.has_rd;
    assign rat_rd_s = q_inst.rd_s;
    assign rat_rd_p = free_preg;

    always_comb begin
        dispatch_entry = '0;
        if (dispatch_valid) begin
            dispatch_entry.inst   = q_inst;
            dispatch_entry.rob_id = rob_id_next;

            // Unused rs1 reads as register 0 and is always ready
            if (q_inst.uses_rs1) begin
                dispatch_entry.rat.rs1    = rat_rs1_p;
                dispatch_entry.input1_met = !busy1;
            end else begin
                dispatch_entry.input1_met = 1'b1;
            end

            // Immediate operand 2 needs no register
            if (!q_inst.uses_imm) begin
                dispatch_entry.rat.rs2    = rat_rs2_p;
                dispatch_entry.input2_met = !busy2;
            end else begin
                dispatch_entry.input2_met = 1'b1;
            end

            // No destination keeps rd at register 0
            if (q_inst.has_rd) begin
                dispatch_entry.rat.rd = free_preg;
            end
        end
    end

endmodule

//--- src/free_list.sv
// Free list of physical registers, circular, filled with the upper registers at reset
module free_list (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pop,
    input  logic                  push,
    input  rename_pkg::phys_reg_t push_preg,
    output rename_pkg::phys_reg_t preg_out,
    output logic                  empty
);

    localparam int ptr_w = $clog2(rename_pkg::free_list_depth);

    rename_pkg::phys_reg_t mem [rename_pkg::free_list_depth];
    logic [ptr_w-1:0] head_ptr;
    logic [ptr_w-1:0] tail_ptr;
    logic [ptr_w:0]   count;

    assign empty = (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // Registers arch_regs and up are free, listed in order
            for (int i = 0; i < rename_pkg::free_list_depth; i++) begin
                mem[i] <= rename_pkg::phys_reg_t'(rename_pkg::arch_regs + i);
            end
            head_ptr <= '0;
            // Full list, tail wraps back onto the head
            tail_ptr <= '0;
            count    <= (ptr_w + 1)'(rename_pkg::free_list_depth);
        end else begin
            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            // Committed register goes to the tail on the same edge
            if (push) begin
                mem[tail_ptr] <= push_preg;
                tail_ptr      <= tail_ptr + 1'b1;
            end
            count <= count + (ptr_w + 1)'(push) - (ptr_w + 1)'(pop);
        end
    end

    // Handed out register, payload only
    always_ff @(posedge clk) begin
        if (pop) begin
            preg_out <= mem[head_ptr];
        end
    end

endmodule

//--- src/inst_queue.sv
// Instruction queue, circular buffer with a visible head and a registered popped entry
module inst_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  rename_pkg::inst_info_t push_data,
    input  logic                   pop,
    output rename_pkg::inst_info_t head,
    output rename_pkg::inst_info_t popped,
    output logic                   empty,
    output logic                   full
);

    localparam int ptr_w = $clog2(rename_pkg::inst_q_depth);

    rename_pkg::inst_info_t mem [rename_pkg::inst_q_depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w:0]   count;
    logic             do_push;
    logic             do_pop;

    // Push into a full queue is dropped, pop is only issued when non-empty
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == (ptr_w + 1)'(rename_pkg::inst_q_depth));

    // Head is visible before the pop so the dispatcher can check has_rd
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (ptr_w + 1)'(do_push) - (ptr_w + 1)'(do_pop);
        end
    end

    // Storage and popped entry carry no reset
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop) begin
            // Held steady for the dispatch cycle
            popped <= head;
        end
    end

endmodule

//--- src/phys_reg_status.sv
// Busy bits per physical register with a writeback bypass on the query ports
module phys_reg_status (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  set_valid,
    input  rename_pkg::phys_reg_t set_preg,
    input  logic                  wb_valid,
    input  rename_pkg::phys_reg_t wb_preg,
    input  rename_pkg::phys_reg_t q1_preg,
    input  rename_pkg::phys_reg_t q2_preg,
    output logic                  q1_busy,
    output logic                  q2_busy
);

    logic [rename_pkg::phys_regs-1:0] busy;

    // Same-cycle writeback reads as not busy
    assign q1_busy = busy[q1_preg] && !(wb_valid && (wb_preg == q1_preg));
    assign q2_busy = busy[q2_preg] && !(wb_valid && (wb_preg == q2_preg));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_preg] <= 1'b0;
            end
            // Later assignment, so a set beats a clear of the same register
            // Register 0 is never marked
            if (set_valid && (set_preg != '0)) begin
                busy[set_preg] <= 1'b1;
            end
        end
    end

endmodule

//--- src/rename_dispatch_top.sv
// Rename and dispatch front end, queue, free list, alias table, busy bits and dispatcher
module rename_dispatch_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        inst_push,
    input  rename_pkg::inst_info_t      inst_in,
    output logic                        inst_q_full,
    input  logic                        rs_full,
    input  logic                        rob_full,
    input  rename_pkg::rob_id_t         rob_id_next,
    input  logic                        wb_valid,
    input  rename_pkg::phys_reg_t       wb_preg,
    input  logic                        free_valid,
    input  rename_pkg::phys_reg_t       free_preg,
    output logic                        dispatch_valid,
    output rename_pkg::dispatch_entry_t dispatch_entry
);

    rename_pkg::inst_info_t q_head;
    rename_pkg::inst_info_t q_inst;
    logic                   q_empty;
    logic                   pop_inst;
    logic                   fl_pop;
    logic                   fl_empty;
    rename_pkg::phys_reg_t  fl_preg;
    rename_pkg::arch_reg_t  rat_rs1_s;
    rename_pkg::arch_reg_t  rat_rs2_s;
    rename_pkg::phys_reg_t  rat_rs1_p;
    rename_pkg::phys_reg_t  rat_rs2_p;
    logic                   rat_we;
    rename_pkg::arch_reg_t  rat_rd_s;
    rename_pkg::phys_reg_t  rat_rd_p;
    logic                   busy1;
    logic                   busy2;

    inst_queue i_inst_queue (
        .clk, .rst,
        .push(inst_push), .push_data(inst_in), .pop(pop_inst),
        .head(q_head), .popped(q_inst), .empty(q_empty), .full(inst_q_full)
    );

    // Commit returns feed the tail
    free_list i_free_list (
        .clk, .rst,
        .pop(fl_pop), .push(free_valid), .push_preg(free_preg),
        .preg_out(fl_preg), .empty(fl_empty)
    );

    rename_table i_rename_table (
        .clk, .rst,
        .rs1_s(rat_rs1_s), .rs2_s(rat_rs2_s), .rs1_p(rat_rs1_p), .rs2_p(rat_rs2_p),
        .we(rat_we), .rd_s(rat_rd_s), .rd_p(rat_rd_p)
    );

    // Queried with the renamed sources, marked with the new rd
    phys_reg_status i_phys_reg_status (
        .clk, .rst,
        .set_valid(rat_we), .set_preg(rat_rd_p),
        .wb_valid, .wb_preg,
        .q1_preg(rat_rs1_p), .q2_preg(rat_rs2_p), .q1_busy(busy1), .q2_busy(busy2)
    );

    dispatcher i_dispatcher (
        .clk, .rst,
        .q_empty, .q_head, .q_inst, .pop_inst,
        .rs_full, .rob_full, .fl_empty, .fl_pop, .free_preg(fl_preg),
        .rat_rs1_s, .rat_rs2_s, .rat_rs1_p, .rat_rs2_p,
        .rat_we, .rat_rd_s, .rat_rd_p,
        .busy1, .busy2, .rob_id_next,
        .dispatch_valid, .dispatch_entry
    );

endmodule

//--- src/rename_pkg.sv
// Rename package with core sizes, register index types and dispatch structs
package rename_pkg;

    // Register file sizes
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;

    // Registers above the identity mapping start out free
    localparam int free_list_depth = phys_regs - arch_regs;

    // Decoded instruction buffering
    localparam int inst_q_depth = 8;

    // Reorder buffer size, only used for the tag width here
    localparam int rob_depth = 16;

    // Register indices
    typedef logic [$clog2(arch_regs)-1:0] arch_reg_t;
    typedef logic [$clog2(phys_regs)-1:0] phys_reg_t;

    // Reorder buffer tag
    typedef logic [$clog2(rob_depth)-1:0] rob_id_t;

    // Decoded instruction as written into the instruction queue
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        arch_reg_t   rs1_s;
        arch_reg_t   rs2_s;
        arch_reg_t   rd_s;
        // Low for lui, auipc and jal
        logic        uses_rs1;
        // Operand 2 comes from the immediate
        logic        uses_imm;
        // Low for x0 destinations and instructions with no rd
        logic        has_rd;
    } inst_info_t;

    // Physical registers picked at rename
    typedef struct packed {
        phys_reg_t rs1;
        phys_reg_t rs2;
        phys_reg_t rd;
    } rename_map_t;

    // Entry handed to the reservation station and the reorder buffer
    typedef struct packed {
        inst_info_t  inst;
        rename_map_t rat;
        rob_id_t     rob_id;
        // Operand ready flags at dispatch time
        logic        input1_met;
        logic        input2_met;
    } dispatch_entry_t;

endpackage

//--- src/rename_table.sv
// Register alias table mapping architectural to physical registers
module rename_table (
    input  logic                  clk,
    input  logic                  rst,
    input  rename_pkg::arch_reg_t rs1_s,
    input  rename_pkg::arch_reg_t rs2_s,
    output rename_pkg::phys_reg_t rs1_p,
    output rename_pkg::phys_reg_t rs2_p,
    input  logic                  we,
    input  rename_pkg::arch_reg_t rd_s,
    input  rename_pkg::phys_reg_t rd_p
);

    rename_pkg::phys_reg_t map [rename_pkg::arch_regs];

    // Combinational source lookups
    assign rs1_p = map[rs1_s];
    assign rs2_p = map[rs2_s];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping, x0 stays on physical register 0
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                map[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (we && (rd_s != '0)) begin
            // x0 keeps its mapping
            map[rd_s] <= rd_p;
        end
    end

endmodule
